//--- source/jtag_cfg.svh
`ifndef JTAG_CFG_SVH
`define JTAG_CFG_SVH

// Instruction register
`define JTAG_IR_WIDTH       4
`define JTAG_IR_BYPASS      4'hF
`define JTAG_IR_IDCODE      4'h1
`define JTAG_IR_REG_ACCESS  4'h8

// Device identification, LSB set as IEEE 1149.1 requires
`define JTAG_IDCODE         32'h1A5C_E07F

// Register access scan
`define JTAG_ADDR_WIDTH     7
`define JTAG_DATA_WIDTH     32
`define JTAG_DR_WIDTH       40

// Register map
`define JTAG_NUM_CFG        8
`define JTAG_NUM_STAT       8
`define JTAG_CFG_BASE       7'h00
`define JTAG_STAT_BASE      7'h10
`define JTAG_CTRL_ADDR      7'h20

`endif

//--- source/jtag_pkg.sv
`include "jtag_cfg.svh"

package jtag_pkg;

	typedef struct packed {
		logic tck;
		logic tms;
		logic tdi;
		logic trst_n;
	} jtag_pins_t;

	// Pins after synchronization, with tck edges as pulses
	typedef struct packed {
		logic tms;
		logic tdi;
		logic rise;
		logic fall;
	} tck_sample_t;

	// Usual IEEE 1149.1 encoding
	typedef enum logic [3:0] {
		TAP_EXIT2_DR     = 4'h0,
		TAP_EXIT1_DR     = 4'h1,
		TAP_SHIFT_DR     = 4'h2,
		TAP_PAUSE_DR     = 4'h3,
		TAP_SELECT_IR    = 4'h4,
		TAP_UPDATE_DR    = 4'h5,
		TAP_CAPTURE_DR   = 4'h6,
		TAP_SELECT_DR    = 4'h7,
		TAP_EXIT2_IR     = 4'h8,
		TAP_EXIT1_IR     = 4'h9,
		TAP_SHIFT_IR     = 4'hA,
		TAP_PAUSE_IR     = 4'hB,
		TAP_IDLE         = 4'hC,
		TAP_UPDATE_IR    = 4'hD,
		TAP_CAPTURE_IR   = 4'hE,
		TAP_RESET        = 4'hF
	} tap_state_e;

	typedef struct packed {
		logic write;
		logic [`JTAG_ADDR_WIDTH-1:0] addr;
		logic [`JTAG_DATA_WIDTH-1:0] data;
	} reg_cmd_t;

	typedef struct packed {
		logic ok;
		logic [`JTAG_ADDR_WIDTH-1:0] addr;
		logic [`JTAG_DATA_WIDTH-1:0] data;
	} reg_rsp_t;

	// Shifted in as a command, captured as a response
	typedef union packed {
		reg_cmd_t cmd;
		reg_rsp_t rsp;
	} jtag_dr_u;

	typedef struct packed {
		logic async;
		logic main;
		logic mdll_ref;
		logic mdll_mon;
	} ibuf_disable_t;

	typedef struct packed {
		logic mdll;
		logic analog;
		logic cdr;
		logic prbs;
		logic sram;
	} sub_rstn_t;

	typedef struct packed {
		logic [`JTAG_DATA_WIDTH-$bits(ibuf_disable_t)-$bits(sub_rstn_t)-1:0] unused;
		ibuf_disable_t ibuf_dis;
		sub_rstn_t sub_rstn;
	} ctrl_word_t;

endpackage

//--- source/tck_sampler.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_cfg.svh"

module tck_sampler import jtag_pkg::*; (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire jtag_pins_t pins_i,
	output tck_sample_t smp_o,
	output logic trst_n_o
);

	jtag_pins_t meta_q;
	jtag_pins_t sync_q;
	logic tck_d_q;

	// Two flops for metastability, then the edge register
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			tck_d_q <= 1'b0;
			smp_o <= '0;
			trst_n_o <= 1'b0;
		end else begin
			meta_q <= pins_i;
			sync_q <= meta_q;
			tck_d_q <= sync_q.tck;

			// tms and tdi stay aligned with the edge pulses
			smp_o.tms <= sync_q.tms;
			smp_o.tdi <= sync_q.tdi;
			smp_o.rise <= sync_q.tck & ~tck_d_q;
			smp_o.fall <= ~sync_q.tck & tck_d_q;

			trst_n_o <= sync_q.trst_n;
		end
	end

endmodule

`default_nettype wire

//--- source/tap_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_cfg.svh"

module tap_fsm import jtag_pkg::*; (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic trst_n_i,
	input wire tck_sample_t smp_i,
	output tap_state_e state_o,
	output logic [`JTAG_IR_WIDTH-1:0] instr_o
);

	tap_state_e state_nxt;
	logic [`JTAG_IR_WIDTH-1:0] ir_shift_q;

	always_comb begin
		case (state_o)
			TAP_RESET:      state_nxt = smp_i.tms ? TAP_RESET : TAP_IDLE;
			TAP_IDLE:       state_nxt = smp_i.tms ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_DR:  state_nxt = smp_i.tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_nxt = smp_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_nxt = smp_i.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_nxt = smp_i.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_nxt = smp_i.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_nxt = smp_i.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_nxt = smp_i.tms ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_IR:  state_nxt = smp_i.tms ? TAP_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_nxt = smp_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_nxt = smp_i.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_nxt = smp_i.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_nxt = smp_i.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_nxt = smp_i.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			TAP_UPDATE_IR:  state_nxt = smp_i.tms ? TAP_SELECT_DR : TAP_IDLE;
			default:        state_nxt = TAP_RESET;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || !trst_n_i) begin
			state_o <= TAP_RESET;
			instr_o <= `JTAG_IR_IDCODE;
		end else begin
			if (smp_i.rise) begin
				state_o <= state_nxt;
			end

			// New instruction takes effect on the falling edge in Update-IR
			if (state_o == TAP_RESET) begin
				instr_o <= `JTAG_IR_IDCODE;
			end else if (state_o == TAP_UPDATE_IR && smp_i.fall) begin
				instr_o <= ir_shift_q;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (smp_i.rise) begin
			if (state_o == TAP_CAPTURE_IR) begin
				ir_shift_q <= {{(`JTAG_IR_WIDTH-2){1'b0}}, 2'b01};
			end else if (state_o == TAP_SHIFT_IR) begin
				ir_shift_q <= {smp_i.tdi, ir_shift_q[`JTAG_IR_WIDTH-1:1]};
			end
		end
	end

	a_instr_change: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$stable(instr_o) |->
			($past(state_o) inside {TAP_UPDATE_IR, TAP_RESET}) || !$past(trst_n_i));

	a_state_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(state_o));

endmodule

`default_nettype wire

//--- source/dr_chain.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_cfg.svh"

module dr_chain import jtag_pkg::*; (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire tck_sample_t smp_i,
	input wire tap_state_e state_i,
	input wire logic [`JTAG_IR_WIDTH-1:0] instr_i,
	input wire reg_rsp_t rsp_i,
	output logic cmd_valid_o,
	output logic capture_o,
	output reg_cmd_t cmd_o,
	output logic tdo_o
);

	logic bypass_q;
	logic [`JTAG_DATA_WIDTH-1:0] idcode_q;
	jtag_dr_u dr_q;
	logic in_update_q;

	logic sel_idcode;
	logic sel_reg;
	logic shift_out;

	// Anything not recognised falls back to bypass
	assign sel_idcode = (instr_i == `JTAG_IR_IDCODE);
	assign sel_reg = (instr_i == `JTAG_IR_REG_ACCESS);

	always_comb begin
		if (sel_reg) begin
			shift_out = dr_q[0];
		end else if (sel_idcode) begin
			shift_out = idcode_q[0];
		end else begin
			shift_out = bypass_q;
		end
	end

	assign capture_o = smp_i.rise && (state_i == TAP_CAPTURE_DR) && sel_reg;
	assign cmd_o = dr_q.cmd;

	// Bypass bit, captured as 0
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			bypass_q <= 1'b0;
		end else if (smp_i.rise && !sel_reg && !sel_idcode) begin
			if (state_i == TAP_CAPTURE_DR) begin
				bypass_q <= 1'b0;
			end else if (state_i == TAP_SHIFT_DR) begin
				bypass_q <= smp_i.tdi;
			end
		end
	end

	// IDCODE and register access chains, LSB out first
	always_ff @(posedge clk) begin
		if (smp_i.rise && state_i == TAP_CAPTURE_DR) begin
			if (sel_idcode) begin
				idcode_q <= `JTAG_IDCODE;
			end
			if (sel_reg) begin
				dr_q.rsp <= rsp_i;
			end
		end else if (smp_i.rise && state_i == TAP_SHIFT_DR) begin
			if (sel_idcode) begin
				idcode_q <= {smp_i.tdi, idcode_q[`JTAG_DATA_WIDTH-1:1]};
			end
			if (sel_reg) begin
				dr_q <= jtag_dr_u'({smp_i.tdi, dr_q[`JTAG_DR_WIDTH-1:1]});
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tdo_o <= 1'b0;
		end else if (state_i == TAP_RESET) begin
			tdo_o <= 1'b0;
		end else if (smp_i.fall) begin
			tdo_o <= (state_i == TAP_SHIFT_DR) ? shift_out : 1'b0;
		end
	end

	// One pulse the cycle after Update-DR is entered
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			in_update_q <= 1'b0;
			cmd_valid_o <= 1'b0;
		end else begin
			in_update_q <= (state_i == TAP_UPDATE_DR);
			cmd_valid_o <= (state_i == TAP_UPDATE_DR) && !in_update_q && sel_reg;
		end
	end

	a_cmd_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		cmd_valid_o |=> !cmd_valid_o);

endmodule

`default_nettype wire

//--- source/debug_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_cfg.svh"

module debug_reg_bank import jtag_pkg::*; (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic cmd_valid_i,
	input wire reg_cmd_t cmd_i,
	input wire logic capture_i,
	input wire logic [`JTAG_NUM_STAT-1:0][`JTAG_DATA_WIDTH-1:0] status_i,
	output reg_rsp_t rsp_o,
	output logic [`JTAG_NUM_CFG-1:0][`JTAG_DATA_WIDTH-1:0] cfg_o,
	output sub_rstn_t sub_rstn_o,
	output ibuf_disable_t ibuf_disable_o
);

	ctrl_word_t ctrl_q;
	ctrl_word_t ctrl_nxt;
	logic last_write_q;
	logic [`JTAG_ADDR_WIDTH-1:0] last_addr_q;
	logic [`JTAG_DATA_WIDTH-1:0] last_wdata_q;
	logic [`JTAG_DATA_WIDTH-1:0] stat_snap_q;

	logic [2:0] w_hit;
	logic w_cfg;
	logic w_ctrl;
	logic r_cfg;
	logic r_stat;
	logic r_ctrl;
	logic [$clog2(`JTAG_NUM_CFG)-1:0] w_idx;
	logic [$clog2(`JTAG_NUM_CFG)-1:0] r_cfg_idx;
	logic [$clog2(`JTAG_NUM_STAT)-1:0] r_stat_idx;

	// Returns {ctrl, stat, cfg} hits
	function automatic logic [2:0] addr_hit(input logic [`JTAG_ADDR_WIDTH-1:0] addr);
		logic [`JTAG_ADDR_WIDTH-1:0] cfg_base;
		logic [`JTAG_ADDR_WIDTH-1:0] stat_base;
		cfg_base = `JTAG_CFG_BASE;
		stat_base = `JTAG_STAT_BASE;
		return {addr == `JTAG_CTRL_ADDR,
			addr[`JTAG_ADDR_WIDTH-1:$clog2(`JTAG_NUM_STAT)] ==
				stat_base[`JTAG_ADDR_WIDTH-1:$clog2(`JTAG_NUM_STAT)],
			addr[`JTAG_ADDR_WIDTH-1:$clog2(`JTAG_NUM_CFG)] ==
				cfg_base[`JTAG_ADDR_WIDTH-1:$clog2(`JTAG_NUM_CFG)]};
	endfunction

	assign w_hit = addr_hit(cmd_i.addr);
	assign w_ctrl = w_hit[2];
	assign w_cfg = w_hit[0];
	assign {r_ctrl, r_stat, r_cfg} = addr_hit(last_addr_q);
	assign w_idx = cmd_i.addr[$clog2(`JTAG_NUM_CFG)-1:0];
	assign r_cfg_idx = last_addr_q[$clog2(`JTAG_NUM_CFG)-1:0];
	assign r_stat_idx = last_addr_q[$clog2(`JTAG_NUM_STAT)-1:0];

	always_comb begin
		ctrl_nxt = ctrl_q;
		if (cmd_valid_i && cmd_i.write && w_ctrl) begin
			ctrl_nxt = cmd_i.data;
		end
	end

	// Status writes land nowhere but still count as the last command
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cfg_o <= '0;
			ctrl_q <= '0;
			last_write_q <= 1'b0;
			last_addr_q <= '0;
		end else begin
			ctrl_q <= ctrl_nxt;
			if (cmd_valid_i) begin
				last_write_q <= cmd_i.write;
				last_addr_q <= cmd_i.addr;
				if (cmd_i.write && w_cfg) begin
					cfg_o[w_idx] <= cmd_i.data;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid_i) begin
			last_wdata_q <= cmd_i.data;
		end
		if (capture_i) begin
			stat_snap_q <= status_i[r_stat_idx];
		end
	end

	// Subsystem resets follow the chip reset as well as the held bits
	always_ff @(posedge clk) begin
		sub_rstn_o <= ctrl_nxt.sub_rstn & {$bits(sub_rstn_t){rst_n_i}};
	end

	assign ibuf_disable_o = ctrl_q.ibuf_dis;

	always_comb begin
		rsp_o.ok = r_cfg || r_stat || r_ctrl;
		rsp_o.addr = last_addr_q;
		rsp_o.data = '0;
		if (!rsp_o.ok) begin
			rsp_o.data = '0;
		end else if (last_write_q) begin
			rsp_o.data = last_wdata_q;
		end else if (r_cfg) begin
			rsp_o.data = cfg_o[r_cfg_idx];
		end else if (r_stat) begin
			rsp_o.data = capture_i ? status_i[r_stat_idx] : stat_snap_q;
		end else begin
			rsp_o.data = ctrl_q;
		end
	end

	a_update_needs_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$past(cmd_valid_i) && $past(rst_n_i) |->
			$stable(cfg_o) && $stable(ctrl_q) && $stable(sub_rstn_o));

endmodule

`default_nettype wire

//--- source/jtag_debug_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "jtag_cfg.svh"

module jtag_debug_top import jtag_pkg::*; (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire jtag_pins_t pins_i,
	output logic tdo_o,
	input wire logic [`JTAG_NUM_STAT-1:0][`JTAG_DATA_WIDTH-1:0] status_i,
	output logic [`JTAG_NUM_CFG-1:0][`JTAG_DATA_WIDTH-1:0] cfg_o,
	output sub_rstn_t sub_rstn_o,
	output ibuf_disable_t ibuf_disable_o
);

	tck_sample_t smp;
	logic trst_n;
	tap_state_e state;
	logic [`JTAG_IR_WIDTH-1:0] instr;
	logic cmd_valid;
	logic capture;
	reg_cmd_t cmd;
	reg_rsp_t rsp;

	tck_sampler tck_sampler_i (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.pins_i   (pins_i),
		.smp_o    (smp),
		.trst_n_o (trst_n)
	);

	tap_fsm tap_fsm_i (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.trst_n_i (trst_n),
		.smp_i    (smp),
		.state_o  (state),
		.instr_o  (instr)
	);

	dr_chain dr_chain_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.smp_i       (smp),
		.state_i     (state),
		.instr_i     (instr),
		.rsp_i       (rsp),
		.cmd_valid_o (cmd_valid),
		.capture_o   (capture),
		.cmd_o       (cmd),
		.tdo_o       (tdo_o)
	);

	debug_reg_bank debug_reg_bank_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.cmd_valid_i    (cmd_valid),
		.cmd_i          (cmd),
		.capture_i      (capture),
		.status_i       (status_i),
		.rsp_o          (rsp),
		.cfg_o          (cfg_o),
		.sub_rstn_o     (sub_rstn_o),
		.ibuf_disable_o (ibuf_disable_o)
	);

endmodule

`default_nettype wire

//--- verif/jtag_tb.sv
`timescale 1ns/10ps

`include "jtag_cfg.svh"

module jtag_tb import jtag_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int TCK_HALF = 5;

	// Watchdog budget in tck cycles summed over the scans of all tests
	localparam int IR_LEN = `JTAG_IR_WIDTH + 6;
	localparam int REG_LEN = `JTAG_DR_WIDTH + 5;
	localparam int TCK_TOTAL = 6 * (6 + IR_LEN) + 37 + 38
		+ 3 * `JTAG_NUM_CFG * REG_LEN
		+ (2 * `JTAG_NUM_STAT + 3 + 2 * 4) * REG_LEN
		+ 3 * REG_LEN + 6 + 1 + 37;
	localparam int WATCHDOG_CYCLES = TCK_TOTAL * 2 * TCK_HALF * 2 + 4 * RESET_CYCLES + 64;

	logic clk;
	logic rst_n;
	jtag_pins_t pins;
	logic tdo;
	logic [`JTAG_NUM_STAT-1:0][`JTAG_DATA_WIDTH-1:0] status;
	logic [`JTAG_NUM_CFG-1:0][`JTAG_DATA_WIDTH-1:0] cfg;
	sub_rstn_t sub_rstn;
	ibuf_disable_t ibuf_dis;

	int pass_count = 0;
	int fail_count = 0;

	jtag_debug_top dut_i (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.pins_i         (pins),
		.tdo_o          (tdo),
		.status_i       (status),
		.cfg_o          (cfg),
		.sub_rstn_o     (sub_rstn),
		.ibuf_disable_o (ibuf_dis)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic compare(input string test, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", test, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic report_test(input string test, input int errors_at_start);
		$display("%s finished, %0d mismatches", test, fail_count - errors_at_start);
	endtask

	// One tck period with tdo sampled just before the next fall
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo_bit);
		pins.tck = 1'b0;
		pins.tms = tms;
		pins.tdi = tdi;
		repeat (TCK_HALF) @(negedge clk);
		pins.tck = 1'b1;
		repeat (TCK_HALF) @(negedge clk);
		tdo_bit = tdo;
	endtask

	// Ends in Run-Test/Idle
	task automatic goto_reset();
		logic bit_out;
		repeat (5) tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic scan_ir(input logic [`JTAG_IR_WIDTH-1:0] ir);
		logic bit_out;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < `JTAG_IR_WIDTH; i++) begin
			tck_cycle(i == `JTAG_IR_WIDTH - 1, ir[i], bit_out);
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		// Instruction latches on the fall of this cycle
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
		logic bit_out;
		dout = '0;
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_cycle(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_cycle(1'b1, 1'b0, bit_out);
		tck_cycle(1'b0, 1'b0, bit_out);
	endtask

	task automatic reg_write(input logic [`JTAG_ADDR_WIDTH-1:0] addr,
			input logic [`JTAG_DATA_WIDTH-1:0] data);
		logic [63:0] dout;
		scan_dr(`JTAG_DR_WIDTH, 64'({1'b1, addr, data}), dout);
	endtask

	task automatic reg_read(input logic [`JTAG_ADDR_WIDTH-1:0] addr,
			output logic [`JTAG_DR_WIDTH-1:0] rsp);
		logic [63:0] dout;
		scan_dr(`JTAG_DR_WIDTH, 64'({1'b0, addr, 32'h0}), dout);
		// Same read again captures the first one's answer
		scan_dr(`JTAG_DR_WIDTH, 64'({1'b0, addr, 32'h0}), dout);
		rsp = dout[`JTAG_DR_WIDTH-1:0];
	endtask

	task automatic reset_and_idcode();
		string name;
		int start;
		logic bit_out;
		logic [63:0] dout;
		name = "reset_idcode";
		start = fail_count;
		for (int i = 0; i < `JTAG_NUM_CFG; i++) begin
			compare(name, 64'(0), 64'(cfg[i]));
		end
		compare(name, 64'(0), 64'(sub_rstn));
		compare(name, 64'(0), 64'(ibuf_dis));
		compare(name, 64'(0), 64'(tdo));
		// Test-Logic-Reset to Idle with the IR untouched
		tck_cycle(1'b0, 1'b0, bit_out);
		scan_dr(32, 64'(0), dout);
		compare(name, 64'(`JTAG_IDCODE), 64'(dout[31:0]));
		report_test(name, start);
	endtask

	task automatic bypass_shift();
		string name;
		int start;
		logic [31:0] pattern;
		logic [63:0] dout;
		name = "bypass";
		start = fail_count;
		pattern = $urandom();
		goto_reset();
		scan_ir(`JTAG_IR_BYPASS);
		scan_dr(33, 64'(pattern), dout);
		compare(name, 64'({pattern, 1'b0}), 64'(dout[32:0]));
		report_test(name, start);
	endtask

	task automatic cfg_access();
		string name;
		int start;
		logic [`JTAG_DATA_WIDTH-1:0] words [`JTAG_NUM_CFG];
		logic [`JTAG_ADDR_WIDTH-1:0] addr;
		logic [`JTAG_DR_WIDTH-1:0] rsp;
		name = "cfg_access";
		start = fail_count;
		goto_reset();
		scan_ir(`JTAG_IR_REG_ACCESS);
		for (int i = 0; i < `JTAG_NUM_CFG; i++) begin
			words[i] = $urandom();
			addr = 7'(`JTAG_CFG_BASE + i);
			reg_write(addr, words[i]);
			compare(name, 64'(words[i]), 64'(cfg[i]));
		end
		// Any aliasing would have overwritten an earlier word
		for (int i = 0; i < `JTAG_NUM_CFG; i++) begin
			compare(name, 64'(words[i]), 64'(cfg[i]));
		end
		for (int i = 0; i < `JTAG_NUM_CFG; i++) begin
			addr = 7'(`JTAG_CFG_BASE + i);
			reg_read(addr, rsp);
			compare(name, 64'({1'b1, addr, words[i]}), 64'(rsp));
		end
		report_test(name, start);
	endtask

	task automatic status_and_bad_addr();
		string name;
		int start;
		logic [`JTAG_ADDR_WIDTH-1:0] addr;
		logic [`JTAG_ADDR_WIDTH-1:0] bad_addr [4];
		logic [`JTAG_DR_WIDTH-1:0] rsp;
		name = "status_access";
		start = fail_count;
		bad_addr = '{7'h08, 7'h18, 7'h21, 7'h7F};
		for (int i = 0; i < `JTAG_NUM_STAT; i++) begin
			status[i] = $urandom();
		end
		goto_reset();
		scan_ir(`JTAG_IR_REG_ACCESS);
		for (int i = 0; i < `JTAG_NUM_STAT; i++) begin
			addr = 7'(`JTAG_STAT_BASE + i);
			reg_read(addr, rsp);
			compare(name, 64'({1'b1, addr, status[i]}), 64'(rsp));
		end
		// Status words are read-only
		addr = 7'(`JTAG_STAT_BASE + 2);
		reg_write(addr, ~status[2]);
		reg_read(addr, rsp);
		compare(name, 64'({1'b1, addr, status[2]}), 64'(rsp));
		for (int j = 0; j < 4; j++) begin
			reg_read(bad_addr[j], rsp);
			compare(name, 64'({1'b0, bad_addr[j], 32'h0}), 64'(rsp));
		end
		report_test(name, start);
	endtask

	task automatic ctrl_word_access();
		string name;
		int start;
		logic [`JTAG_DATA_WIDTH-1:0] word;
		logic [`JTAG_DR_WIDTH-1:0] rsp;
		name = "ctrl_word";
		start = fail_count;
		// Defined bits only with one reset bit released and one buffer disabled
		word = $urandom() & 32'h0000_01FF;
		word[0] = 1'b1;
		word[5] = 1'b1;
		goto_reset();
		scan_ir(`JTAG_IR_REG_ACCESS);
		reg_write(`JTAG_CTRL_ADDR, word);
		// Reset bits in the low five and buffer disables in the next four
		compare(name, 64'(word[8:5]), 64'(ibuf_dis));
		compare(name, 64'(word[4:0]), 64'(sub_rstn));
		reg_read(`JTAG_CTRL_ADDR, rsp);
		compare(name, 64'({1'b1, `JTAG_CTRL_ADDR, word}), 64'(rsp));
		pins.tck = 1'b0;
		pins.tms = 1'b1;
		rst_n = 1'b0;
		// Reset bits drop at the first edge of the chip reset
		@(negedge clk);
		compare(name, 64'(0), 64'(sub_rstn));
		repeat (RESET_CYCLES - 1) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);
		compare(name, 64'(0), 64'(sub_rstn));
		compare(name, 64'(0), 64'(ibuf_dis));
		report_test(name, start);
	endtask

	task automatic trst_recovery();
		string name;
		int start;
		logic bit_out;
		logic [63:0] dout;
		name = "trst";
		start = fail_count;
		goto_reset();
		scan_ir(`JTAG_IR_REG_ACCESS);
		pins.trst_n = 1'b0;
		repeat (8) @(negedge clk);
		pins.trst_n = 1'b1;
		repeat (4) @(negedge clk);
		tck_cycle(1'b0, 1'b0, bit_out);
		scan_dr(32, 64'(0), dout);
		compare(name, 64'(`JTAG_IDCODE), 64'(dout[31:0]));
		report_test(name, start);
	endtask

	initial begin
		void'($urandom(32'hb6af_b18e));
		pins.tck = 1'b0;
		pins.tms = 1'b1;
		pins.tdi = 1'b0;
		pins.trst_n = 1'b1;
		status = '0;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);

		reset_and_idcode();
		bypass_shift();
		cfg_access();
		status_and_bad_addr();
		ctrl_word_access();
		trst_recovery();

		$display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/jtag_pkg.sv
source/tck_sampler.sv
source/tap_fsm.sv
source/dr_chain.sv
source/debug_reg_bank.sv
source/jtag_debug_top.sv
verif/jtag_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module jtag_tb -f files.f -o jtag_sim

if ! out=$(./obj_dir/jtag_sim); then
	echo "$out"
	echo "Simulation exited with an error"
	exit 1
fi
echo "$out"

echo "$out" | grep -qF '*** TEST PASSED ***'
